// File: Makefile
# Verilator build and run for the PageRank vertex unit testbench
VERILATOR ?= verilator
TOP       ?= tb_cu_vertex_pagerank
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message appears on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
source/pagerank_pkg.sv
source/sync_fifo.sv
source/vertex_job_intake.sv
source/read_data_router.sv
source/edge_array_reader.sv
source/read_command_merge.sv
source/rank_sum_kernel.sv
source/cu_vertex_pagerank.sv
tb/tb_cu_vertex_pagerank.sv

// File: source/cu_vertex_pagerank.sv
// PageRank vertex unit top level for neighbor rank summing per vertex job
`timescale 1ns/1ps

module cu_vertex_pagerank #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                job_req,
	input  pagerank_pkg::vertex_job_t           job,
	output logic                                job_ack,
	output pagerank_pkg::read_cmd_t             read_cmd,
	input  logic                                read_status_alfull,
	input  pagerank_pkg::read_data_t            read_data,
	output pagerank_pkg::write_cmd_t            write_cmd,
	input  logic                                write_status_alfull,
	output logic [pagerank_pkg::COUNT_BITS-1:0] vertex_count,
	output logic [pagerank_pkg::COUNT_BITS-1:0] edge_count
);

	pagerank_pkg::vertex_job_t current_job;
	pagerank_pkg::read_cmd_t   edge_cmd;
	pagerank_pkg::read_data_t  edge_return;
	pagerank_pkg::read_data_t  rank_return;
	logic busy;
	logic vertex_done;
	logic edge_fifo_alfull;

	////////////////////////////////////////////////////////////
	// Job side
	////////////////////////////////////////////////////////////

	vertex_job_intake vertex_job_intake_i (
		.clock      (clock),
		.rstn       (rstn),
		.job_req    (job_req),
		.job        (job),
		.job_ack    (job_ack),
		.vertex_done(vertex_done),
		.current_job(current_job),
		.busy       (busy)
	);

	edge_array_reader edge_array_reader_i (
		.clock           (clock),
		.rstn            (rstn),
		.current_job     (current_job),
		.busy            (busy),
		.edge_fifo_alfull(edge_fifo_alfull),
		.edge_cmd        (edge_cmd)
	);

	////////////////////////////////////////////////////////////
	// Memory read side
	////////////////////////////////////////////////////////////

	read_data_router read_data_router_i (
		.clock      (clock),
		.rstn       (rstn),
		.read_data  (read_data),
		.edge_return(edge_return),
		.rank_return(rank_return)
	);

	read_command_merge #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) read_command_merge_i (
		.clock             (clock),
		.rstn              (rstn),
		.edge_cmd          (edge_cmd),
		.edge_return       (edge_return),
		.read_status_alfull(read_status_alfull),
		.edge_fifo_alfull  (edge_fifo_alfull),
		.read_cmd          (read_cmd)
	);

	rank_sum_kernel rank_sum_kernel_i (
		.clock              (clock),
		.rstn               (rstn),
		.current_job        (current_job),
		.busy               (busy),
		.rank_return        (rank_return),
		.write_status_alfull(write_status_alfull),
		.write_cmd          (write_cmd),
		.vertex_done        (vertex_done),
		.vertex_count       (vertex_count),
		.edge_count         (edge_count)
	);

endmodule

// File: source/edge_array_reader.sv
// Edge-array read issue with one read per edge of the current vertex
`timescale 1ns/1ps

module edge_array_reader (
	input  logic                      clock,
	input  logic                      rstn,
	input  pagerank_pkg::vertex_job_t current_job,
	input  logic                      busy,
	input  logic                      edge_fifo_alfull,
	output pagerank_pkg::read_cmd_t   edge_cmd
);

	logic [pagerank_pkg::COUNT_BITS-1:0] issued;
	logic                                issue;

	assign issue = busy & (issued < current_job.degree) & ~edge_fifo_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issued   <= '0;
			edge_cmd <= '0;
		end else begin
			edge_cmd.valid <= 1'b0;
			if (!busy) begin
				// Ready for the next vertex
				issued <= '0;
			end else if (issue) begin
				issued           <= issued + 1'b1;
				edge_cmd.valid   <= 1'b1;
				edge_cmd.tag     <= pagerank_pkg::EDGE_ARRAY;
				edge_cmd.address <= current_job.edge_start
					+ pagerank_pkg::ADDR_BITS'(issued);
			end
		end
	end

endmodule

// File: source/pagerank_pkg.sv
// Widths, memory region tags, command/response/job types and the memory data word
package pagerank_pkg;

	parameter int VERTEX_BITS = 16;
	parameter int ADDR_BITS   = 16;
	parameter int DATA_BITS   = 32;
	parameter int COUNT_BITS  = 16;

	// Memory region carried as the tag of every read
	typedef enum logic [1:0] {
		EDGE_ARRAY       = 2'd0,
		GRAPH_DATA       = 2'd1,
		WRITE_GRAPH_DATA = 2'd2
	} mem_struct_e;

	// One edge-array entry with the neighbor id in the low half
	typedef struct packed {
		logic [DATA_BITS-VERTEX_BITS-1:0] padding;
		logic [VERTEX_BITS-1:0]           neighbor_id;
	} edge_entry_t;

	// Same word read as a neighbor id or as a rank
	typedef union packed {
		edge_entry_t          edge_entry;
		logic [DATA_BITS-1:0] rank;
	} mem_word_u;

	typedef struct packed {
		logic                 valid;
		mem_struct_e          tag;
		logic [ADDR_BITS-1:0] address;
	} read_cmd_t;

	typedef struct packed {
		logic        valid;
		mem_struct_e tag;
		mem_word_u   data;
	} read_data_t;

	typedef struct packed {
		logic                 valid;
		logic [ADDR_BITS-1:0] address;
		logic [DATA_BITS-1:0] data;
	} write_cmd_t;

	typedef struct packed {
		logic [VERTEX_BITS-1:0] vertex_id;
		logic [ADDR_BITS-1:0]   edge_start;
		logic [COUNT_BITS-1:0]  degree;
	} vertex_job_t;

endpackage

// File: source/rank_sum_kernel.sv
// Rank accumulation, sum write, vertex done and vertex/edge counters
`timescale 1ns/1ps

module rank_sum_kernel (
	input  logic                                clock,
	input  logic                                rstn,
	input  pagerank_pkg::vertex_job_t           current_job,
	input  logic                                busy,
	input  pagerank_pkg::read_data_t            rank_return,
	input  logic                                write_status_alfull,
	output pagerank_pkg::write_cmd_t            write_cmd,
	output logic                                vertex_done,
	output logic [pagerank_pkg::COUNT_BITS-1:0] vertex_count,
	output logic [pagerank_pkg::COUNT_BITS-1:0] edge_count
);

	logic [pagerank_pkg::DATA_BITS-1:0]  sum;
	logic [pagerank_pkg::DATA_BITS-1:0]  sum_next;
	logic [pagerank_pkg::COUNT_BITS-1:0] rank_count;
	logic [pagerank_pkg::COUNT_BITS-1:0] count_next;
	logic                                written;
	logic                                fire;

	// Include the rank arriving this cycle so the write follows it directly
	always_comb begin
		sum_next   = sum;
		count_next = rank_count;
		if (rank_return.valid) begin
			sum_next   = sum + rank_return.data.rank;
			count_next = rank_count + 1'b1;
		end
	end

	assign fire = busy & ~written & (count_next == current_job.degree) & ~write_status_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum          <= '0;
			rank_count   <= '0;
			written      <= 1'b0;
			write_cmd    <= '0;
			vertex_done  <= 1'b0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			write_cmd.valid <= 1'b0;
			vertex_done     <= fire;
			if (rank_return.valid) begin
				edge_count <= edge_count + 1'b1;
			end
			if (fire) begin
				write_cmd.valid   <= 1'b1;
				write_cmd.address <= pagerank_pkg::ADDR_BITS'(current_job.vertex_id);
				write_cmd.data    <= sum_next;
				vertex_count      <= vertex_count + 1'b1;
				sum               <= '0;
				rank_count        <= '0;
			end else begin
				sum        <= sum_next;
				rank_count <= count_next;
			end
			// Blocks a second write until intake drops busy
			if (!busy) begin
				written <= 1'b0;
			end else if (fire) begin
				written <= 1'b1;
			end
		end
	end

endmodule

// File: source/read_command_merge.sv
// Read command merge with edge and rank FIFOs and round-robin issue
`timescale 1ns/1ps

module read_command_merge #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  pagerank_pkg::read_cmd_t  edge_cmd,
	input  pagerank_pkg::read_data_t edge_return,
	input  logic                     read_status_alfull,
	output logic                     edge_fifo_alfull,
	output pagerank_pkg::read_cmd_t  read_cmd
);

	pagerank_pkg::read_cmd_t rank_cmd;
	pagerank_pkg::read_cmd_t edge_fifo_out;
	pagerank_pkg::read_cmd_t rank_fifo_out;
	logic edge_empty;
	logic rank_empty;
	logic pick_rank;
	logic pick_edge;
	logic pop_edge;
	logic pop_rank;
	logic rank_priority;
	logic issue_valid;
	logic issue_rank;

	////////////////////////////////////////////////////////////
	// Rank read from each returned edge entry
	////////////////////////////////////////////////////////////

	always_comb begin
		rank_cmd.valid   = edge_return.valid;
		rank_cmd.tag     = pagerank_pkg::GRAPH_DATA;
		rank_cmd.address = pagerank_pkg::ADDR_BITS'(edge_return.data.edge_entry.neighbor_id);
	end

	sync_fifo #(
		.DEPTH(FIFO_DEPTH),
		.WIDTH($bits(pagerank_pkg::read_cmd_t))
	) edge_cmd_fifo_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_cmd.valid),
		.data_in (edge_cmd),
		.pop     (pop_edge),
		.data_out(edge_fifo_out),
		.full    (),
		.alfull  (edge_fifo_alfull),
		.empty   (edge_empty)
	);

	// Never overflows since degree is at most FIFO_DEPTH
	sync_fifo #(
		.DEPTH(FIFO_DEPTH),
		.WIDTH($bits(pagerank_pkg::read_cmd_t))
	) rank_cmd_fifo_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (rank_cmd.valid),
		.data_in (rank_cmd),
		.pop     (pop_rank),
		.data_out(rank_fifo_out),
		.full    (),
		.alfull  (),
		.empty   (rank_empty)
	);

	////////////////////////////////////////////////////////////
	// Round-robin pick and issue
	////////////////////////////////////////////////////////////

	assign pick_rank = ~rank_empty & (edge_empty | rank_priority);
	assign pick_edge = ~edge_empty & ~pick_rank;
	assign pop_rank  = pick_rank & ~read_status_alfull;
	assign pop_edge  = pick_edge & ~read_status_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rank_priority <= 1'b0;
			issue_valid   <= 1'b0;
			issue_rank    <= 1'b0;
		end else begin
			issue_valid <= pop_rank | pop_edge;
			issue_rank  <= pop_rank;
			if (pop_edge) begin
				rank_priority <= 1'b1;
			end else if (pop_rank) begin
				rank_priority <= 1'b0;
			end
		end
	end

	// FIFO outputs are registered and the issue flags select one
	always_comb begin
		read_cmd = '0;
		if (issue_valid) begin
			read_cmd = issue_rank ? rank_fifo_out : edge_fifo_out;
		end
	end

endmodule

// File: source/read_data_router.sv
// Read data steering by tag onto the edge-array or rank path
`timescale 1ns/1ps

module read_data_router (
	input  logic                     clock,
	input  logic                     rstn,
	input  pagerank_pkg::read_data_t read_data,
	output pagerank_pkg::read_data_t edge_return,
	output pagerank_pkg::read_data_t rank_return
);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_return <= '0;
			rank_return <= '0;
		end else begin
			edge_return <= '0;
			rank_return <= '0;
			if (read_data.valid) begin
				case (read_data.tag)
					pagerank_pkg::EDGE_ARRAY: begin
						edge_return <= read_data;
					end
					pagerank_pkg::GRAPH_DATA: begin
						rank_return <= read_data;
					end
					// No read goes out with any other tag
					default: begin
					end
				endcase
			end
		end
	end

endmodule

// File: source/sync_fifo.sv
// Synchronous FIFO with registered read, full, almost-full and empty flags
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH = 16,
	parameter int WIDTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_W   = $clog2(DEPTH);
	localparam int COUNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]   mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [COUNT_W-1:0] count;
	logic               do_push;
	logic               do_pop;

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;
	assign full    = (count == COUNT_W'(DEPTH));
	// Two slots of headroom for a producer one register away
	assign alfull  = (count >= COUNT_W'(DEPTH - 2));
	assign empty   = (count == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + COUNT_W'(do_push) - COUNT_W'(do_pop);
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

// File: source/vertex_job_intake.sv
// Vertex job intake with four-phase req/ack and the current job register
`timescale 1ns/1ps

module vertex_job_intake (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      job_req,
	input  pagerank_pkg::vertex_job_t job,
	output logic                      job_ack,
	input  logic                      vertex_done,
	output pagerank_pkg::vertex_job_t current_job,
	output logic                      busy
);

	logic accept;

	// Only a fresh request while nothing is in flight
	assign accept = job_req & ~job_ack & ~busy;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_ack <= 1'b0;
			busy    <= 1'b0;
		end else begin
			if (accept) begin
				job_ack <= 1'b1;
			end else if (!job_req) begin
				job_ack <= 1'b0;
			end
			if (accept) begin
				busy <= 1'b1;
			end else if (vertex_done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			current_job <= job;
		end
	end

endmodule

// File: tb/tb_cu_vertex_pagerank.sv
// Testbench for the vertex unit with memory model, job driver, reference sums and checks
`timescale 1ns/1ps

module tb_cu_vertex_pagerank;

	localparam int NUM_JOBS   = 40;
	localparam int EDGE_WORDS = 256;
	localparam int RANK_WORDS = 64;
	localparam int MAX_DEGREE = 16;
	localparam int TIMEOUT    = 400 * NUM_JOBS + 1000;

	typedef struct packed {
		pagerank_pkg::read_cmd_t cmd;
		logic [31:0]             due;
	} pending_read_t;

	logic clock;
	logic rstn;
	logic job_req;
	pagerank_pkg::vertex_job_t job;
	logic job_ack;
	pagerank_pkg::read_cmd_t read_cmd;
	logic read_status_alfull;
	pagerank_pkg::read_data_t read_data;
	pagerank_pkg::write_cmd_t write_cmd;
	logic write_status_alfull;
	logic [pagerank_pkg::COUNT_BITS-1:0] vertex_count;
	logic [pagerank_pkg::COUNT_BITS-1:0] edge_count;

	logic [pagerank_pkg::VERTEX_BITS-1:0] edge_mem [EDGE_WORDS];
	logic [pagerank_pkg::DATA_BITS-1:0]   rank_mem [RANK_WORDS];
	pagerank_pkg::vertex_job_t job_q [$];
	logic [31:0] sum_q [$];
	pending_read_t pending [$];
	logic [pagerank_pkg::VERTEX_BITS-1:0] neighbor_ids [$];
	logic [MAX_DEGREE-1:0] edge_seen;
	int edge_reads;
	int rank_reads;
	int writes_seen;
	int acks_seen;
	int jobs_sent;
	int degree_total;
	int error_count;
	int check_count;
	int timeout_cycles;
	int mem_cycle;
	logic stress;
	logic prev_req;
	logic prev_ack;
	logic read_af_prev;
	logic write_af_prev;

	cu_vertex_pagerank #(
		.FIFO_DEPTH(MAX_DEGREE)
	) cu_vertex_pagerank_i (
		.clock              (clock),
		.rstn               (rstn),
		.job_req            (job_req),
		.job                (job),
		.job_ack            (job_ack),
		.read_cmd           (read_cmd),
		.read_status_alfull (read_status_alfull),
		.read_data          (read_data),
		.write_cmd          (write_cmd),
		.write_status_alfull(write_status_alfull),
		.vertex_count       (vertex_count),
		.edge_count         (edge_count)
	);

	always #5 clock = ~clock;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error: %s is 0x%08h, expected 0x%08h", name, got, expected);
		end
	endtask

	task automatic report_problem(input string what);
		error_count++;
		$display("Failure: %s", what);
	endtask

	////////////////////////////////////////////////////////////
	// Memory model, back-pressure and timeout
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		timeout_cycles++;
		if (timeout_cycles >= TIMEOUT) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("Done: errors found");
			$finish;
		end
	end

	always @(posedge clock) begin
		read_status_alfull  <= stress && ($urandom % 4 == 0);
		write_status_alfull <= stress && ($urandom % 4 == 0);
	end

	// Responses come 1 to 6 cycles late and the second pending one may go first
	always @(posedge clock) begin : memory_model
		pending_read_t entry;
		pagerank_pkg::read_data_t rsp;
		int pick;
		mem_cycle++;
		rsp = '0;
		if (read_cmd.valid) begin
			entry.cmd = read_cmd;
			entry.due = 32'(mem_cycle) + 32'd1 + ($urandom % 6);
			pending.push_back(entry);
		end
		pick = (pending.size() > 1 && $urandom % 2 == 1) ? 1 : 0;
		if (pending.size() > 0 && pending[pick].due <= 32'(mem_cycle)) begin
			rsp.valid = 1'b1;
			rsp.tag   = pending[pick].cmd.tag;
			if (rsp.tag == pagerank_pkg::EDGE_ARRAY) begin
				rsp.data.edge_entry.padding     = 16'($urandom);
				rsp.data.edge_entry.neighbor_id = edge_mem[pending[pick].cmd.address[7:0]];
				neighbor_ids.push_back(rsp.data.edge_entry.neighbor_id);
			end else begin
				rsp.data.rank = rank_mem[pending[pick].cmd.address[5:0]];
			end
			pending.delete(pick);
		end
		read_data <= rsp;
	end

	////////////////////////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////////////////////////

	// Samples the values of the cycle that just ended
	always @(posedge clock) begin : monitor
		pagerank_pkg::vertex_job_t cur;
		logic [pagerank_pkg::ADDR_BITS-1:0] offset;
		int idx;
		if (rstn) begin
			if (job_ack && !prev_ack) begin
				if (!prev_req) begin
					report_problem("job_ack rose while job_req was low");
				end
				compare("job_ack count before write", 32'(acks_seen), 32'(writes_seen));
				acks_seen++;
			end
			if (read_cmd.valid) begin
				if (read_af_prev) begin
					report_problem("read_cmd valid right after read_status_alfull was high");
				end
				if (job_q.size() == 0) begin
					report_problem("read_cmd issued with no job outstanding");
				end else begin
					cur = job_q[0];
					case (read_cmd.tag)
						pagerank_pkg::EDGE_ARRAY: begin
							offset = read_cmd.address - cur.edge_start;
							if (offset >= cur.degree || edge_seen[offset[3:0]]) begin
								report_problem("edge-array read outside the job or repeated");
							end else begin
								edge_seen[offset[3:0]] = 1'b1;
							end
							edge_reads++;
						end
						pagerank_pkg::GRAPH_DATA: begin
							idx = -1;
							foreach (neighbor_ids[i]) begin
								if (idx < 0 && neighbor_ids[i] == read_cmd.address) begin
									idx = i;
								end
							end
							if (idx < 0) begin
								report_problem("rank read of an id no edge entry returned");
							end else begin
								neighbor_ids.delete(idx);
							end
							rank_reads++;
						end
						default: begin
							report_problem("read_cmd carries an unknown tag");
						end
					endcase
				end
			end
			if (write_cmd.valid) begin
				if (write_af_prev) begin
					report_problem("write_cmd valid right after write_status_alfull was high");
				end
				if (job_q.size() == 0) begin
					report_problem("write_cmd issued with no job outstanding");
				end else begin
					compare("write_cmd.address", 32'(write_cmd.address), 32'(job_q[0].vertex_id));
					compare("write_cmd.data", write_cmd.data, sum_q[0]);
					compare("read_cmd EDGE_ARRAY count", 32'(edge_reads), 32'(job_q[0].degree));
					compare("read_cmd GRAPH_DATA count", 32'(rank_reads), 32'(job_q[0].degree));
					void'(job_q.pop_front());
					void'(sum_q.pop_front());
				end
				edge_seen  = '0;
				edge_reads = 0;
				rank_reads = 0;
				writes_seen++;
			end
		end
		prev_req      = job_req;
		prev_ack      = job_ack;
		read_af_prev  = read_status_alfull;
		write_af_prev = write_status_alfull;
	end

	////////////////////////////////////////////////////////////
	// Job driver and reference model
	////////////////////////////////////////////////////////////

	task automatic make_job(output pagerank_pkg::vertex_job_t j, output logic [31:0] sum);
		j.vertex_id  = 16'($urandom);
		j.edge_start = 16'($urandom % (EDGE_WORDS - MAX_DEGREE));
		j.degree     = 16'($urandom % (MAX_DEGREE + 1));
		sum = '0;
		// Wrapping sum of the neighbor ranks
		for (int i = 0; i < int'(j.degree); i++) begin
			sum += rank_mem[edge_mem[int'(j.edge_start) + i]];
		end
	endtask

	task automatic send_job(input pagerank_pkg::vertex_job_t j);
		job_req <= 1'b1;
		job     <= j;
		do @(posedge clock); while (!job_ack);
		job_req <= 1'b0;
		do @(posedge clock); while (job_ack);
	endtask

	task automatic run_jobs(input string name, input int count, input logic pressure);
		pagerank_pkg::vertex_job_t j;
		logic [31:0] sum;
		int errors_before;
		errors_before = error_count;
		stress <= pressure;
		for (int n = 0; n < count; n++) begin
			make_job(j, sum);
			job_q.push_back(j);
			sum_q.push_back(sum);
			degree_total += int'(j.degree);
			jobs_sent++;
			send_job(j);
		end
		while (writes_seen < jobs_sent) @(posedge clock);
		repeat (4) @(posedge clock);
		stress <= 1'b0;
		$display("Test %s: %s", name, (error_count == errors_before) ? "passed" : "failed");
	endtask

	initial begin : main
		int errors_before;
		void'($urandom(32'h1626b35a));
		clock               = 1'b0;
		rstn                = 1'b0;
		job_req             = 1'b0;
		job                 = '0;
		read_status_alfull  = 1'b0;
		write_status_alfull = 1'b0;
		read_data           = '0;
		stress              = 1'b0;
		prev_req            = 1'b0;
		prev_ack            = 1'b0;
		read_af_prev        = 1'b0;
		write_af_prev       = 1'b0;
		edge_seen           = '0;
		foreach (edge_mem[i]) begin
			edge_mem[i] = 16'($urandom % RANK_WORDS);
		end
		foreach (rank_mem[i]) begin
			rank_mem[i] = $urandom;
		end

		repeat (3) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		errors_before = error_count;
		compare("job_ack", 32'(job_ack), 32'd0);
		compare("read_cmd.valid", 32'(read_cmd.valid), 32'd0);
		compare("write_cmd.valid", 32'(write_cmd.valid), 32'd0);
		compare("vertex_count", 32'(vertex_count), 32'd0);
		compare("edge_count", 32'(edge_count), 32'd0);
		$display("Test reset values: %s", (error_count == errors_before) ? "passed" : "failed");

		run_jobs("jobs without back-pressure", NUM_JOBS / 2, 1'b0);
		run_jobs("jobs with random back-pressure", NUM_JOBS - NUM_JOBS / 2, 1'b1);

		errors_before = error_count;
		compare("vertex_count", 32'(vertex_count), 32'(jobs_sent));
		compare("edge_count", 32'(edge_count), 32'(degree_total));
		compare("unmatched neighbor ids", 32'(neighbor_ids.size()), 32'd0);
		$display("Test final counters: %s", (error_count == errors_before) ? "passed" : "failed");

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
